//--- sources.f
+incdir+src
src/or1420HubPkg.sv
src/systemController.sv
src/gpioSlave.sv
src/pixelCustomInstructions.sv
src/or1420Hub.sv
verification/or1420HubTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator and run; a $fatal in the testbench gives a failing exit status
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module or1420HubTb -Mdir obj_dir \
  && ./obj_dir/Vor1420HubTb \
  || { echo "Simulation build or run failed"; exit 1; }

//--- verification/or1420HubTb.sv
`default_nettype none

`include "or1420Hub_cfg.svh"

module or1420HubTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HalfPeriod     = 50;
  localparam int DriveDelay     = 10;
  localparam int ResetCycles    = 16;
  localparam int ReleaseEdges   = 16;
  localparam int TimeoutCycles  = `OR1420_BUS_TIMEOUT_CYCLES;
  localparam int WatchdogCycles = 3000;  // About five times the test length
  localparam int NrOfOutBytes   = `OR1420_GPIO_OUTPUTS / 8;
  localparam logic [31:0] GpioBase = `OR1420_GPIO_BASE;

  logic                             s_systemClock;
  logic                             s_pllLocked;
  or1420HubPkg::busRequest_t        busRequest;
  or1420HubPkg::ciRequest_t         ciRequest;
  logic [`OR1420_GPIO_INPUTS-1:0]   dipSwitch;
  or1420HubPkg::busResponse_t       busResponse;
  or1420HubPkg::ciResponse_t        ciResponse;
  logic [`OR1420_GPIO_OUTPUTS-1:0]  gpioOutputs;
  logic                             peripheralResetN;

  integer                           seed;
  logic [`OR1420_GPIO_OUTPUTS-1:0]  outputModel;

  or1420Hub i_or1420Hub (
    .s_systemClock    (s_systemClock),
    .s_pllLocked      (s_pllLocked),
    .busRequest       (busRequest),
    .ciRequest        (ciRequest),
    .dipSwitch        (dipSwitch),
    .busResponse      (busResponse),
    .ciResponse       (ciResponse),
    .gpioOutputs      (gpioOutputs),
    .peripheralResetN (peripheralResetN)
  );

  always #(HalfPeriod) s_systemClock = ~s_systemClock;  // 100 ns period

  // ========================================
  // Failure reporting
  // ========================================

  task automatic failText(input string reason);
    $display("sim failed");
    $display("%s", reason);
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic failValue(input string name, input logic [63:0] got,
                           input logic [63:0] expected);
    failText($sformatf("ERROR: %s is 0x%0h, expected 0x%0h", name, got, expected));
  endtask

  // ========================================
  // Timing and reference models
  // ========================================

  task automatic driveSlot();
    @(posedge s_systemClock);
    #(DriveDelay);
  endtask

  task automatic sampleSlot();
    @(negedge s_systemClock);  // Mid-cycle, all outputs settled
  endtask

  function automatic logic [31:0] reverseBytes(input logic [31:0] word);
    logic [31:0] reversed;
    for (int i = 0; i < 4; i++) begin
      reversed[8*i +: 8] = word[8*(3-i) +: 8];
    end
    return reversed;
  endfunction

  function automatic logic [31:0] grayOf(input logic [15:0] pixel);
    int red;
    int green;
    int blue;
    red   = int'(pixel[15:11]) * 8;
    green = int'(pixel[10:5]) * 4;
    blue  = int'(pixel[4:0]) * 8;
    return 32'((54 * red + 183 * green + 19 * blue) / 256);
  endfunction

  // ========================================
  // Stimulus tasks
  // ========================================

  task automatic checkSilentBus();
    assert (busResponse == '0)
      else failValue("busResponse", 64'(busResponse), 64'd0);
  endtask

  task automatic watchIdleBus(input int cycles);
    repeat (cycles) begin
      driveSlot();
      sampleSlot();
      checkSilentBus();
    end
  endtask

  task automatic checkCustom(input logic start, input logic [7:0] number,
                             input logic [31:0] operand, input logic expectedDone,
                             input logic [31:0] expectedResult);
    driveSlot();
    ciRequest.start = start;
    ciRequest.n     = number;
    ciRequest.dataA = operand;
    ciRequest.dataB = 32'($random(seed));  // Ignored by both instructions
    sampleSlot();
    assert (ciResponse.done == expectedDone)
      else failValue("ciResponse.done", 64'(ciResponse.done), 64'(expectedDone));
    assert (ciResponse.result == expectedResult)
      else failValue("ciResponse.result", 64'(ciResponse.result), 64'(expectedResult));
  endtask

  task automatic busWrite(input logic [31:0] address, input logic [31:0] data,
                          input logic [3:0] enables);
    driveSlot();
    busRequest                  = '0;
    busRequest.beginTransaction = 1'b1;
    busRequest.addressData      = address;
    busRequest.byteEnables      = enables;
    sampleSlot();
    checkSilentBus();
    driveSlot();
    busRequest.beginTransaction = 1'b0;
    busRequest.dataValid        = 1'b1;
    busRequest.addressData      = data;
    busRequest.byteEnables      = '0;  // Enables belong to the begin cycle
    sampleSlot();
    checkSilentBus();
    assert (gpioOutputs == outputModel)
      else failValue("gpioOutputs", 64'(gpioOutputs), 64'(outputModel));
    if (address == GpioBase + 32'd4) begin
      for (int i = 0; i < NrOfOutBytes; i++) begin
        if (enables[i]) begin
          outputModel[8*i +: 8] = data[8*i +: 8];
        end
      end
    end
    driveSlot();
    busRequest.dataValid      = 1'b0;
    busRequest.endTransaction = 1'b1;
    busRequest.addressData    = '0;
    sampleSlot();
    checkSilentBus();
    assert (gpioOutputs == outputModel)
      else failValue("gpioOutputs", 64'(gpioOutputs), 64'(outputModel));
    driveSlot();
    busRequest = '0;
  endtask

  task automatic busRead(input logic [31:0] address, input logic [31:0] expected);
    driveSlot();
    busRequest                  = '0;
    busRequest.beginTransaction = 1'b1;
    busRequest.readNotWrite     = 1'b1;
    busRequest.addressData      = address;
    busRequest.byteEnables      = 4'hF;
    sampleSlot();
    checkSilentBus();
    driveSlot();
    busRequest = '0;
    sampleSlot();
    assert (busResponse.endTransaction && busResponse.dataValid)
      else failText("GPIO read gave no response one cycle after begin");
    assert (busResponse.addressData == expected)
      else failValue("busResponse.addressData", 64'(busResponse.addressData), 64'(expected));
    driveSlot();
    sampleSlot();
    checkSilentBus();  // Answer lasts one cycle only
  endtask

  task automatic timeoutRead(input logic [31:0] address);
    or1420HubPkg::busResponse_t errorResponse;
    errorResponse                = '0;
    errorResponse.endTransaction = 1'b1;
    errorResponse.busError       = 1'b1;
    driveSlot();
    busRequest                  = '0;
    busRequest.beginTransaction = 1'b1;
    busRequest.readNotWrite     = 1'b1;
    busRequest.addressData      = address;
    sampleSlot();
    checkSilentBus();
    driveSlot();
    busRequest = '0;
    for (int cycle = 1; cycle < TimeoutCycles; cycle++) begin
      sampleSlot();
      checkSilentBus();  // No early error
      driveSlot();
    end
    sampleSlot();
    assert (busResponse == errorResponse)
      else failValue("busResponse", 64'(busResponse), 64'(errorResponse));
    driveSlot();
    sampleSlot();
    checkSilentBus();
  endtask

  // A slave answer never carries the watchdog error
  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
                   !(busResponse.dataValid && busResponse.busError))
    else failText("Bus error raised together with read data");

  // ========================================
  // Test sequence
  // ========================================

  initial begin
    logic [7:0]  foreignNumber;
    logic [31:0] operand;
    logic [31:0] data;
    seed          = 52;
    s_systemClock = 1'b0;
    s_pllLocked   = 1'b0;
    busRequest    = '0;
    ciRequest     = '0;
    dipSwitch     = '0;
    outputModel   = '0;

    repeat (ResetCycles) begin
      driveSlot();
      sampleSlot();
      assert (!peripheralResetN)
        else failValue("peripheralResetN", 64'(peripheralResetN), 64'd0);
      checkSilentBus();
      assert (gpioOutputs == '0)
        else failValue("gpioOutputs", 64'(gpioOutputs), 64'd0);
      assert (ciResponse == '0)
        else failValue("ciResponse", 64'(ciResponse), 64'd0);
    end
    driveSlot();
    s_pllLocked = 1'b1;
    for (int edgeCount = 1; edgeCount <= ReleaseEdges; edgeCount++) begin
      @(posedge s_systemClock);
      sampleSlot();
      assert (peripheralResetN == (edgeCount == ReleaseEdges))
        else failValue("peripheralResetN", 64'(peripheralResetN),
                       64'(edgeCount == ReleaseEdges));
    end

    repeat (100) begin
      operand = 32'($random(seed));
      checkCustom(1'b1, `OR1420_CI_SWAP_BYTE, operand, 1'b1, reverseBytes(operand));
    end
    repeat (100) begin
      operand = 32'($random(seed));
      checkCustom(1'b1, `OR1420_CI_GRAYSCALE, operand, 1'b1, grayOf(operand[15:0]));
    end
    repeat (20) begin
      foreignNumber = 8'($random(seed));
      while (foreignNumber == `OR1420_CI_SWAP_BYTE || foreignNumber == `OR1420_CI_GRAYSCALE) begin
        foreignNumber = 8'($random(seed));
      end
      checkCustom(1'b1, foreignNumber, 32'($random(seed)), 1'b0, 32'd0);
    end
    checkCustom(1'b0, `OR1420_CI_SWAP_BYTE, 32'($random(seed)), 1'b0, 32'd0);
    driveSlot();
    ciRequest = '0;

    // GPIO output register with partial byte enables
    repeat (30) begin
      data = 32'($random(seed));
      busWrite(GpioBase + 32'd4, data, 4'($random(seed)));
      busRead(GpioBase + 32'd4, 32'(outputModel));
    end
    busWrite(GpioBase + 32'd8, 32'($random(seed)), 4'hF);  // Ignored offset
    busRead(GpioBase + 32'd4, 32'(outputModel));
    busRead(GpioBase + 32'd8, 32'd0);
    busRead(GpioBase + 32'd12, 32'd0);

    repeat (8) begin
      driveSlot();
      dipSwitch = 8'($random(seed));
      repeat (2) driveSlot();  // Through the synchronizer
      busRead(GpioBase, 32'(dipSwitch));
    end

    // Ended transfers leave the watchdog quiet
    busRead(GpioBase + 32'd4, 32'(outputModel));
    watchIdleBus(TimeoutCycles + 2);
    busWrite(GpioBase + 32'd4, 32'($random(seed)), 4'hF);
    watchIdleBus(TimeoutCycles + 2);

    repeat (3) begin
      timeoutRead(32'h80000000 | (32'($random(seed)) & 32'h0FFFFFFC));
    end

    $display("sim passed");
    $finish;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge s_systemClock);
    failText("Timeout: the test did not finish within the watchdog limit");
  end

endmodule

`default_nettype wire

//--- src/or1420Hub.sv
`default_nettype none

`include "or1420Hub_cfg.svh"

module or1420Hub (
  input  wire                              s_systemClock,
  input  wire                              s_pllLocked,
  input  wire or1420HubPkg::busRequest_t   busRequest,
  input  wire or1420HubPkg::ciRequest_t    ciRequest,
  input  wire [`OR1420_GPIO_INPUTS-1:0]    dipSwitch,
  output or1420HubPkg::busResponse_t       busResponse,
  output or1420HubPkg::ciResponse_t        ciResponse,
  output logic [`OR1420_GPIO_OUTPUTS-1:0]  gpioOutputs,
  output logic                             peripheralResetN
);

  logic                       systemReset;
  or1420HubPkg::busResponse_t controllerResponse;
  or1420HubPkg::busResponse_t gpioResponse;

  // ========================================
  // Reset and watchdog
  // ========================================

  systemController i_systemController (
    .s_systemClock    (s_systemClock),
    .s_pllLocked      (s_pllLocked),
    .busRequest       (busRequest),
    .slaveEnd         (gpioResponse.endTransaction),  // Only slave on the bus
    .systemReset      (systemReset),
    .peripheralResetN (peripheralResetN),
    .busResponse      (controllerResponse)
  );

  // ========================================
  // Bus slaves
  // ========================================

  gpioSlave i_gpioSlave (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .systemReset   (systemReset),
    .busRequest    (busRequest),
    .dipSwitch     (dipSwitch),
    .busResponse   (gpioResponse),
    .gpioOutputs   (gpioOutputs)
  );

  // ========================================
  // Custom instructions
  // ========================================

  pixelCustomInstructions i_pixelCustomInstructions (
    .ciRequest  (ciRequest),
    .ciResponse (ciResponse)
  );

  // Wired-OR of all responders
  assign busResponse = or1420HubPkg::busResponse_t'(controllerResponse | gpioResponse);

endmodule

`default_nettype wire

//--- src/pixelCustomInstructions.sv
`default_nettype none

`include "or1420Hub_cfg.svh"

module pixelCustomInstructions (
  input  wire or1420HubPkg::ciRequest_t ciRequest,
  output or1420HubPkg::ciResponse_t     ciResponse
);

  logic        swapSelect;
  logic        graySelect;
  logic [31:0] swapResult;
  logic [7:0]  red;
  logic [7:0]  green;
  logic [7:0]  blue;
  logic [15:0] graySum;
  logic [31:0] grayResult;

  assign swapSelect = ciRequest.start && (ciRequest.n == `OR1420_CI_SWAP_BYTE);
  assign graySelect = ciRequest.start && (ciRequest.n == `OR1420_CI_GRAYSCALE);

  // ========================================
  // Byte swap
  // ========================================

  assign swapResult = {ciRequest.dataA[7:0],
                       ciRequest.dataA[15:8],
                       ciRequest.dataA[23:16],
                       ciRequest.dataA[31:24]};

  // ========================================
  // RGB565 to grayscale
  // ========================================

  // Widen each channel to 8 bits
  assign red   = {ciRequest.dataA[15:11], 3'b000};
  assign green = {ciRequest.dataA[10:5], 2'b00};
  assign blue  = {ciRequest.dataA[4:0], 3'b000};

  // Weights sum to 256 so the total fits in 16 bits
  assign graySum = (16'd54 * {8'd0, red}) +
                   (16'd183 * {8'd0, green}) +
                   (16'd19 * {8'd0, blue});

  assign grayResult = {24'd0, graySum[15:8]};  // Divide by 256

  // Idle or foreign numbers answer with zeros
  always_comb begin
    ciResponse        = '0;
    ciResponse.done   = swapSelect | graySelect;
    ciResponse.result = (swapSelect ? swapResult : 32'd0) |
                        (graySelect ? grayResult : 32'd0);
  end

endmodule

`default_nettype wire

//--- src/gpioSlave.sv
`default_nettype none

`include "or1420Hub_cfg.svh"

module gpioSlave (
  input  wire                                s_systemClock,
  input  wire                                s_pllLocked,
  input  wire                                systemReset,
  input  wire or1420HubPkg::busRequest_t     busRequest,
  input  wire [`OR1420_GPIO_INPUTS-1:0]      dipSwitch,
  output or1420HubPkg::busResponse_t         busResponse,
  output logic [`OR1420_GPIO_OUTPUTS-1:0]    gpioOutputs
);

  localparam logic [31:0] GpioBase      = `OR1420_GPIO_BASE;
  localparam int          NrOfOutBytes  = `OR1420_GPIO_OUTPUTS / 8;
  localparam logic [1:0]  SwitchOffset  = 2'd0;  // Byte offset 0
  localparam logic [1:0]  OutputOffset  = 2'd1;  // Byte offset 4

  logic [`OR1420_GPIO_INPUTS-1:0] dipMeta;
  logic [`OR1420_GPIO_INPUTS-1:0] dipSync;
  logic                           hit;
  logic [1:0]                     offsetReg;
  logic [NrOfOutBytes-1:0]        enableReg;
  logic                           readActive;
  logic                           writeActive;
  logic [31:0]                    readData;

  // ========================================
  // DIP switch synchronizer
  // ========================================

  always_ff @(posedge s_systemClock) begin
    dipMeta <= dipSwitch;
    dipSync <= dipMeta;
  end

  // ========================================
  // Address decode
  // ========================================

  assign hit = (busRequest.addressData[31:4] == GpioBase[31:4]);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      readActive  <= 1'b0;
      writeActive <= 1'b0;
      offsetReg   <= '0;
      enableReg   <= '0;
    end else if (systemReset) begin
      readActive  <= 1'b0;
      writeActive <= 1'b0;
      offsetReg   <= '0;
      enableReg   <= '0;
    end else begin
      // Read answer lasts exactly one cycle
      readActive <= busRequest.beginTransaction & hit & busRequest.readNotWrite;
      if (busRequest.beginTransaction) begin
        writeActive <= hit & ~busRequest.readNotWrite;
        offsetReg   <= busRequest.addressData[3:2];
        enableReg   <= busRequest.byteEnables[NrOfOutBytes-1:0];  // Valid with begin only
      end else if (busRequest.dataValid | busRequest.endTransaction) begin
        writeActive <= 1'b0;  // Single-word write is done
      end
    end
  end

  // ========================================
  // Output register
  // ========================================

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      gpioOutputs <= '0;
    end else if (systemReset) begin
      gpioOutputs <= '0;
    end else if (writeActive && busRequest.dataValid && (offsetReg == OutputOffset)) begin
      for (int i = 0; i < NrOfOutBytes; i++) begin
        if (enableReg[i]) begin
          gpioOutputs[i*8 +: 8] <= busRequest.addressData[i*8 +: 8];
        end
      end
    end
  end

  // ========================================
  // Read response
  // ========================================

  always_comb begin
    case (offsetReg)
      SwitchOffset : readData = 32'(dipSync);
      OutputOffset : readData = 32'(gpioOutputs);
      default      : readData = '0;  // Offsets 8 and 12
    endcase
  end

  always_comb begin
    busResponse                = '0;
    busResponse.endTransaction = readActive;
    busResponse.dataValid      = readActive;
    busResponse.addressData    = readActive ? readData : 32'd0;
  end

endmodule

`default_nettype wire

//--- src/systemController.sv
`default_nettype none

`include "or1420Hub_cfg.svh"

module systemController (
  input  wire                            s_systemClock,
  input  wire                            s_pllLocked,
  input  wire or1420HubPkg::busRequest_t busRequest,
  input  wire                            slaveEnd,
  output logic                           systemReset,
  output logic                           peripheralResetN,
  output or1420HubPkg::busResponse_t     busResponse
);

  localparam int ResetTopBit = `OR1420_RESET_COUNT_BITS - 1;
  localparam int TimeoutBits = $clog2(`OR1420_BUS_TIMEOUT_CYCLES);
  localparam logic [TimeoutBits-1:0] LastCount = TimeoutBits'(`OR1420_BUS_TIMEOUT_CYCLES - 1);

  logic [`OR1420_RESET_COUNT_BITS-1:0] resetCount;
  logic                                busyFlag;
  logic [TimeoutBits-1:0]              timeoutCount;
  logic                                timeoutPulse;
  logic                                transactionEnd;

  // ========================================
  // Reset sequencing
  // ========================================

  // Counts up after lock and freezes once the top bit is set
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[ResetTopBit]) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign peripheralResetN = resetCount[ResetTopBit];
  assign systemReset      = ~resetCount[ResetTopBit];

  // ========================================
  // Bus timeout watchdog
  // ========================================

  assign transactionEnd = busRequest.endTransaction | slaveEnd;  // Master or slave closed it

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      busyFlag     <= 1'b0;
      timeoutCount <= '0;
      timeoutPulse <= 1'b0;
    end else if (systemReset) begin
      busyFlag     <= 1'b0;
      timeoutCount <= '0;
      timeoutPulse <= 1'b0;
    end else begin
      timeoutPulse <= 1'b0;
      if (busRequest.beginTransaction) begin
        busyFlag     <= 1'b1;
        timeoutCount <= TimeoutBits'(1);  // One clock already spent on begin
      end else if (busyFlag) begin
        if (transactionEnd) begin
          busyFlag <= 1'b0;
        end else if (timeoutCount == LastCount) begin
          // Nobody answered, force the end with an error
          busyFlag     <= 1'b0;
          timeoutPulse <= 1'b1;
        end else begin
          timeoutCount <= timeoutCount + 1'b1;
        end
      end
    end
  end

  always_comb begin
    busResponse                = '0;
    busResponse.endTransaction = timeoutPulse;
    busResponse.busError       = timeoutPulse;
  end

endmodule

`default_nettype wire

//--- src/or1420HubPkg.sv
`default_nettype none

package or1420HubPkg;

  // ========================================
  // Shared wired-OR bus
  // ========================================

  // Driven by the single master
  typedef struct packed {
    logic        beginTransaction;
    logic        endTransaction;
    logic        readNotWrite;
    logic        dataValid;
    logic [31:0] addressData;
    logic [3:0]  byteEnables;
  } busRequest_t;

  // Idle responders drive all zeros so responses can be ORed
  typedef struct packed {
    logic        endTransaction;
    logic        dataValid;
    logic        busError;
    logic [31:0] addressData;
  } busResponse_t;

  // ========================================
  // Custom instruction port
  // ========================================

  typedef struct packed {
    logic        start;
    logic [7:0]  n;      // Instruction number
    logic [31:0] dataA;
    logic [31:0] dataB;
  } ciRequest_t;

  typedef struct packed {
    logic        done;
    logic [31:0] result;
  } ciResponse_t;

endpackage

`default_nettype wire

//--- src/or1420Hub_cfg.svh
`ifndef OR1420HUB_CFG_SVH
`define OR1420HUB_CFG_SVH

// ========================================
// Reset sequencing and bus watchdog
// ========================================

// Top bit of the counter releases reset after 16 counts
`define OR1420_RESET_COUNT_BITS 5

`define OR1420_BUS_TIMEOUT_CYCLES 16  // Clocks a transaction may stay open

// ========================================
// Peripherals
// ========================================

`define OR1420_GPIO_BASE 32'h40000000  // Decodes a 16-byte region
`define OR1420_GPIO_INPUTS 8
`define OR1420_GPIO_OUTPUTS 24

// Custom instruction numbers
`define OR1420_CI_SWAP_BYTE 8'd1
`define OR1420_CI_GRAYSCALE 8'd9

`endif
